/* verilog.f */
rtl/mmu_geom_pkg.sv
rtl/mmu_seq_pkg.sv
rtl/mac_pe.sv
rtl/operand_skewer.sv
rtl/systolic_array.sv
rtl/mmu_sequencer.sv
rtl/mmu_top.sv
verification/mmu_tb.sv

/* Makefile */
# Verilator build for the matrix-multiply unit

TOOL     = verilator
FLAGS    = --binary --timing
TOP      = mmu_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ ! -s $(LOG) ]; then echo "No simulation log"; exit 1; fi; \
	if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD) $(LOG)

/* verification/mmu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mmu_tb;

    localparam int N = mmu_geom_pkg::N;
    localparam int RUN = mmu_seq_pkg::RUN_CYCLES;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   beat_valid;
    mmu_geom_pkg::operand_t a_col  [N];
    mmu_geom_pkg::operand_t b_row  [N];
    logic                   busy;
    logic                   done;
    mmu_geom_pkg::acc_t     result [N][N];

    // Operand matrices and expected product
    mmu_geom_pkg::operand_t mat_a [N][N];
    mmu_geom_pkg::operand_t mat_b [N][N];
    mmu_geom_pkg::acc_t     exp_c [N][N];

    logic [15:0] lfsr_state;
    int          value_errors;
    int          timeout_errors;
    int          runs_checked;
    event        run_launched;

    mmu_top DUT (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .beat_valid (beat_valid),
        .a_col      (a_col),
        .b_row      (b_row),
        .busy       (busy),
        .done       (done),
        .result     (result)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit
    function automatic mmu_geom_pkg::operand_t rand_operand();
        mmu_geom_pkg::operand_t v;
        v = '0;
        for (int b = 0; b < mmu_geom_pkg::OPERAND_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[mmu_geom_pkg::OPERAND_W-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // C = A x B, signed, wraps at ACC_W
    function automatic void compute_reference();
        mmu_geom_pkg::acc_t sum;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                sum = '0;
                for (int k = 0; k < N; k++) begin
                    sum = sum + mmu_geom_pkg::acc_t'(mat_a[i][k])
                              * mmu_geom_pkg::acc_t'(mat_b[k][j]);
                end
                exp_c[i][j] = sum;
            end
        end
    endfunction

    function automatic void fill_random();
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                mat_a[i][j] = rand_operand();
                mat_b[i][j] = rand_operand();
            end
        end
    endfunction

    // Drive point, 10 ns past the rising edge
    task automatic next_slot();
        @(posedge clk);
        #10;
    endtask

    task automatic check_acc(input string name, input mmu_geom_pkg::acc_t expected,
                             input mmu_geom_pkg::acc_t actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_result_matrix(input bit expect_zero);
        mmu_geom_pkg::acc_t exp_v;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                exp_v = expect_zero ? '0 : exp_c[i][j];
                check_acc($sformatf("result[%0d][%0d]", i, j), exp_v, result[i][j]);
            end
        end
    endtask

    // Garbage on idle lanes, the skewers must gate it
    task automatic idle_lanes();
        beat_valid = 1'b0;
        for (int i = 0; i < N; i++) begin
            a_col[i] = 8'sh5A;
            b_row[i] = -8'sd77;
        end
    endtask

    // Column k of A and row k of B
    task automatic drive_beat(input int k);
        beat_valid = 1'b1;
        for (int i = 0; i < N; i++) begin
            a_col[i] = mat_a[i][k];
            b_row[i] = mat_b[k][i];
        end
    endtask

    task automatic wait_checked(input int target);
        int guard;
        guard = 0;
        while (runs_checked < target && guard < 8 * RUN) begin
            next_slot();
            guard++;
        end
        if (runs_checked < target) begin
            $display("ERROR: checker did not finish run %0d in time", target);
            timeout_errors++;
        end
    endtask

    // Start pulse, N beats, then wait for the checker
    // Stray start rides on beat 2 when asked
    task automatic launch_run(input bit stray_start);
        int target;
        target = runs_checked + 1;
        compute_reference();
        start = 1'b1;
        ->run_launched;
        next_slot();
        for (int k = 0; k < N; k++) begin
            drive_beat(k);
            start = stray_start && (k == 2);
            next_slot();
        end
        start = 1'b0;
        idle_lanes();
        wait_checked(target);
    endtask

    //////////////////////////////
    // Checker
    //////////////////////////////

    // Samples at the falling edge, counting edges from the start edge
    initial begin : run_monitor
        int n;
        bit seen;
        forever begin
            @(run_launched);
            n = -1;
            seen = 1'b0;
            while (!seen && n < 4 * RUN) begin
                @(posedge clk);
                n++;
                @(negedge clk);
                check_level("done", n == RUN, done);
                check_level("busy", n < RUN, busy);
                seen = done;
            end
            if (!seen) begin
                $display("ERROR: done never pulsed within %0d cycles of start", 4 * RUN);
                timeout_errors++;
            end else begin
                check_result_matrix(1'b0);
                // One cycle later, pulse gone and sums held
                @(posedge clk);
                @(negedge clk);
                check_level("done", 1'b0, done);
                check_level("busy", 1'b0, busy);
                check_result_matrix(1'b0);
            end
            runs_checked++;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        idle_lanes();
        lfsr_state = 16'd47336;
        value_errors = 0;
        timeout_errors = 0;
        runs_checked = 0;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        next_slot();

        // Identity A, so C equals B
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                mat_a[i][j] = (i == j) ? 8'sd1 : 8'sd0;
                mat_b[i][j] = mmu_geom_pkg::operand_t'(i * 37 - j * 11 - 20);
            end
        end
        launch_run(1'b0);

        // Extremes, -128 and 127 mixed
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                mat_a[i][j] = ((i + j) % 2 == 0) ? -8'sd128 : 8'sd127;
                mat_b[i][j] = ((i + j) % 2 == 1) ? -8'sd128 : 8'sd127;
            end
        end
        launch_run(1'b0);

        // Consecutive random runs, no residue allowed
        repeat (3) begin
            fill_random();
            launch_run(1'b0);
        end

        // Start while busy must be dropped
        fill_random();
        launch_run(1'b1);

        // Reset in the middle of a run
        fill_random();
        start = 1'b1;
        next_slot();
        start = 1'b0;
        for (int k = 0; k < 3; k++) begin
            drive_beat(k);
            next_slot();
        end
        idle_lanes();
        rst = 1'b1;
        @(negedge clk);
        check_level("busy", 1'b0, busy);
        check_level("done", 1'b0, done);
        check_result_matrix(1'b1);
        next_slot();
        rst = 1'b0;
        // Aborted run must never reach its done edge
        repeat (RUN) begin
            @(negedge clk);
            check_level("done", 1'b0, done);
            check_level("busy", 1'b0, busy);
        end
        next_slot();

        // Clean run after the reset
        fill_random();
        launch_run(1'b0);

        $display("Summary: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/mmu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mmu_top (
    input  logic                    clk,
    input  logic                    rst,
    // Accepted only while idle
    input  logic                    start,
    // High for the N beats after start
    input  logic                    beat_valid,
    // A[i][k] on lane i
    input  mmu_geom_pkg::operand_t  a_col  [mmu_geom_pkg::N],
    // B[k][j] on lane j
    input  mmu_geom_pkg::operand_t  b_row  [mmu_geom_pkg::N],
    output logic                    busy,
    output logic                    done,
    // C = A x B, held until the next accepted start
    output mmu_geom_pkg::acc_t      result [mmu_geom_pkg::N][mmu_geom_pkg::N]
);

    //////////////////////////////
    // Internal nets
    //////////////////////////////

    // Skewed operands at the array edges
    mmu_geom_pkg::operand_t west_edge  [mmu_geom_pkg::N];
    mmu_geom_pkg::operand_t north_edge [mmu_geom_pkg::N];

    // Accumulator reset from the sequencer
    logic clear;

    // Rows of A staggered onto the left edge
    operand_skewer west_skew (
        .clk      (clk),
        .rst      (rst),
        .valid    (beat_valid),
        .lane_in  (a_col),
        .lane_out (west_edge)
    );

    // Columns of B staggered onto the top edge
    operand_skewer north_skew (
        .clk      (clk),
        .rst      (rst),
        .valid    (beat_valid),
        .lane_in  (b_row),
        .lane_out (north_edge)
    );

    // MAC grid
    systolic_array u_array (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .west_in  (west_edge),
        .north_in (north_edge),
        .acc      (result)
    );

    // Start, clear, busy and done
    mmu_sequencer u_seq (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .clear (clear),
        .busy  (busy),
        .done  (done)
    );

endmodule

`default_nettype wire

/* rtl/mmu_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module mmu_sequencer (
    input  logic clk,
    input  logic rst,
    // One-cycle request from the host
    input  logic start,
    // Zeroes the accumulators on the start edge
    output logic clear,
    output logic busy,
    // One-cycle pulse, sums are final
    output logic done
);

    mmu_seq_pkg::seq_state_t         state;
    logic [mmu_seq_pkg::CNT_W-1:0]   cnt;
    logic                            accept;

    // Starts while running are dropped
    assign accept = start && (state == mmu_seq_pkg::SEQ_IDLE);

    // Clear coincides with the accepted start edge
    assign clear = accept;

    // High from the start edge until the done cycle
    assign busy = (state == mmu_seq_pkg::SEQ_RUN);

    //////////////////////////////
    // Run FSM
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mmu_seq_pkg::SEQ_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            // Done is a pulse by default
            done <= 1'b0;
            case (state)
                mmu_seq_pkg::SEQ_IDLE: begin
                    if (accept) begin
                        state <= mmu_seq_pkg::SEQ_RUN;
                        cnt   <= '0;
                    end
                end
                mmu_seq_pkg::SEQ_RUN: begin
                    // cnt counts edges since the start edge, minus one
                    if (int'(cnt) == mmu_seq_pkg::RUN_CYCLES - 1) begin
                        state <= mmu_seq_pkg::SEQ_IDLE;
                        done  <= 1'b1;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= mmu_seq_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/systolic_array.sv */
`timescale 1ns/1ns
`default_nettype none

module systolic_array (
    input  logic                    clk,
    input  logic                    rst,
    // Broadcast to every cell
    input  logic                    clear,
    // Row i of A enters on the left
    input  mmu_geom_pkg::operand_t  west_in  [mmu_geom_pkg::N],
    // Column j of B enters on top
    input  mmu_geom_pkg::operand_t  north_in [mmu_geom_pkg::N],
    output mmu_geom_pkg::acc_t      acc      [mmu_geom_pkg::N][mmu_geom_pkg::N]
);

    //////////////////////////////
    // Inter-cell nets
    //////////////////////////////

    // Row index N is the spare bottom edge
    mmu_geom_pkg::operand_t south_net [0:mmu_geom_pkg::N][0:mmu_geom_pkg::N-1];
    // Column index N is the spare right edge
    mmu_geom_pkg::operand_t east_net  [0:mmu_geom_pkg::N-1][0:mmu_geom_pkg::N];

    genvar i, j;

    // Edge ties
    generate
        for (j = 0; j < mmu_geom_pkg::N; j++) begin : g_north_edge
            assign south_net[0][j] = north_in[j];
        end
        for (i = 0; i < mmu_geom_pkg::N; i++) begin : g_west_edge
            assign east_net[i][0] = west_in[i];
        end
    endgenerate

    //////////////////////////////
    // Cell grid
    //////////////////////////////

    // Cell (i,j) sees beat k in cycle k+1+i+j
    generate
        for (i = 0; i < mmu_geom_pkg::N; i++) begin : g_row
            for (j = 0; j < mmu_geom_pkg::N; j++) begin : g_col
                mac_pe u_pe (
                    .clk   (clk),
                    .rst   (rst),
                    .clear (clear),
                    .north (south_net[i][j]),
                    .west  (east_net[i][j]),
                    .south (south_net[i+1][j]),
                    .east  (east_net[i][j+1]),
                    .acc   (acc[i][j])
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* rtl/operand_skewer.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_skewer (
    input  logic                    clk,
    input  logic                    rst,
    // High during the N operand beats
    input  logic                    valid,
    input  mmu_geom_pkg::operand_t  lane_in  [mmu_geom_pkg::N],
    output mmu_geom_pkg::operand_t  lane_out [mmu_geom_pkg::N]
);

    // Lanes after idle beats are zeroed
    mmu_geom_pkg::operand_t lane_gated [mmu_geom_pkg::N];

    genvar i;
    generate
        for (i = 0; i < mmu_geom_pkg::N; i++) begin : g_lane
            // Stale bus values never reach an accumulator
            assign lane_gated[i] = valid ? lane_in[i] : '0;

            if (i == 0) begin : g_pass
                // Lane 0 goes straight through
                assign lane_out[i] = lane_gated[i];
            end else begin : g_delay
                // Shift chain of depth i
                mmu_geom_pkg::operand_t chain [0:i-1];

                always_ff @(posedge clk or posedge rst) begin
                    if (rst) begin
                        for (int k = 0; k < i; k++) begin
                            chain[k] <= '0;
                        end
                    end else begin
                        chain[0] <= lane_gated[i];
                        for (int k = 1; k < i; k++) begin
                            chain[k] <= chain[k-1];
                        end
                    end
                end

                // Oldest stage is the diagonal wavefront
                assign lane_out[i] = chain[i-1];
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* rtl/mac_pe.sv */
`timescale 1ns/1ns
`default_nettype none

module mac_pe (
    input  logic                    clk,
    input  logic                    rst,
    // Zero the sum on this edge
    input  logic                    clear,
    input  mmu_geom_pkg::operand_t  north,
    input  mmu_geom_pkg::operand_t  west,
    output mmu_geom_pkg::operand_t  south,
    output mmu_geom_pkg::operand_t  east,
    output mmu_geom_pkg::acc_t      acc
);

    // Full precision product before extension
    logic signed [2*mmu_geom_pkg::OPERAND_W-1:0] product;

    assign product = north * west;

    // Operands move on one hop per cycle
    // North feeds the cell below, west the cell to the right
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            south <= '0;
            east  <= '0;
        end else begin
            south <= north;
            east  <= west;
        end
    end

    // Output-stationary sum for one element of C
    // Clear wins over the add on the start edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else begin
            // Sign extend, then wrap at ACC_W
            acc <= acc + mmu_geom_pkg::acc_t'(product);
        end
    end

endmodule

`default_nettype wire

/* rtl/mmu_seq_pkg.sv */
`default_nettype none

//////////////////////////////
// Run control
//////////////////////////////

package mmu_seq_pkg;

    // Start edge to done pulse, in edges
    // Last product lands at 3N-2, done follows one edge later
    localparam int RUN_CYCLES = 3 * mmu_geom_pkg::N - 1;

    // Counter wide enough to hold RUN_CYCLES
    localparam int CNT_W = $clog2(RUN_CYCLES + 1);

    // Sequencer states
    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_t;

endpackage

`default_nettype wire

/* rtl/mmu_geom_pkg.sv */
`default_nettype none

//////////////////////////////
// Array geometry
//////////////////////////////

package mmu_geom_pkg;

    // Rows and columns of the grid
    // Also the number of operand beats per run
    localparam int N = 4;

    // Matrix element width, signed
    localparam int OPERAND_W = 8;

    // Result element width, signed, wraps on overflow
    localparam int ACC_W = 32;

    // Element of A or B
    typedef logic signed [OPERAND_W-1:0] operand_t;

    // Element of C
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire
